//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

   localparam int XLEN       = 32;
   localparam int REG_COUNT  = 32;
   localparam int REG_ADDR_W = 5;
   localparam int IMM_W      = 16;

   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [XLEN-1:0]       word_t;

   // Primary opcodes
   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_XORI  = 6'h01;
   localparam logic [5:0] OP_SUBI  = 6'h02;
   localparam logic [5:0] OP_ADDI  = 6'h03;
   localparam logic [5:0] OP_ORI   = 6'h0C;
   localparam logic [5:0] OP_ANDI  = 6'h0F;
   localparam logic [5:0] OP_LW    = 6'h1E;
   localparam logic [5:0] OP_SW    = 6'h1F;
   localparam logic [5:0] OP_BEQ   = 6'h30;
   localparam logic [5:0] OP_BNE   = 6'h31;

   // Funct codes of the R-format group
   localparam logic [5:0] FN_XOR = 6'h01;
   localparam logic [5:0] FN_SUB = 6'h02;
   localparam logic [5:0] FN_ADD = 6'h03;
   localparam logic [5:0] FN_OR  = 6'h04;
   localparam logic [5:0] FN_AND = 6'h07;
   localparam logic [5:0] FN_SLT = 6'h36;
   localparam logic [5:0] FN_SLE = 6'h37;

   typedef enum logic [2:0] {
      ALU_XOR = 3'd0,
      ALU_SUB = 3'd1,
      ALU_ADD = 3'd2,
      ALU_OR  = 3'd3,
      ALU_AND = 3'd4
   } alu_op_e;

   typedef enum logic [1:0] {
      SET_NONE = 2'd0,
      SET_LT   = 2'd1,
      SET_LE   = 2'd2
   } set_mode_e;

   typedef struct packed {
      logic [5:0] opcode;
      reg_addr_t  rs;
      reg_addr_t  rt;
      reg_addr_t  rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } r_fields_t;

   typedef struct packed {
      logic [5:0]       opcode;
      reg_addr_t        rs;
      reg_addr_t        rt;
      logic [IMM_W-1:0] imm;
   } i_fields_t;

   // Same word, two views
   typedef union packed {
      r_fields_t r;
      i_fields_t i;
   } instr_u;

   typedef struct packed {
      word_t     a;
      word_t     b;
      word_t     imm;
      logic      use_imm;
      alu_op_e   alu_op;
      set_mode_e set_mode;
      reg_addr_t dest;
      logic      reg_write;
      logic      mem_read;
      logic      mem_write;
   } id_ex_t;

   typedef struct packed {
      word_t     result;
      word_t     store_data;
      reg_addr_t dest;
      logic      reg_write;
      logic      mem_read;
      logic      mem_write;
   } ex_mem_t;

   typedef struct packed {
      logic      we;
      reg_addr_t dest;
      word_t     data;
   } wb_t;

endpackage

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
   input  logic            clk,
   input  logic            reset,
   input  logic            branch_taken,
   input  cpu_pkg::word_t  branch_target,
   output cpu_pkg::word_t  imem_addr,
   input  cpu_pkg::word_t  imem_data,
   output cpu_pkg::instr_u instr,
   output cpu_pkg::word_t  pc_next_seq
);
   import cpu_pkg::*;

   word_t pc_plus4;

   assign pc_plus4 = imem_addr + word_t'(4);

   // The PC itself drives the instruction address
   always_ff @(posedge clk) begin
      if (reset) begin
         imem_addr <= '0;
      end else if (branch_taken) begin
         imem_addr <= branch_target;
      end else begin
         imem_addr <= pc_plus4;
      end
   end

   // Fetch/decode register, all-zero word is the no-op
   always_ff @(posedge clk) begin
      pc_next_seq <= pc_plus4;
      if (reset) begin
         instr <= '0;
      end else begin
         instr <= imem_data;
      end
   end

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
   input  logic              clk,
   input  cpu_pkg::reg_addr_t rs_addr,
   input  cpu_pkg::reg_addr_t rt_addr,
   output cpu_pkg::word_t    rs_data,
   output cpu_pkg::word_t    rt_data,
   input  cpu_pkg::wb_t      wb
);
   import cpu_pkg::*;

   word_t regs [REG_COUNT];

   always_ff @(posedge clk) begin
      if (wb.we) begin
         regs[wb.dest] <= wb.data;
      end
   end

   // Write-through so a read in the writeback cycle sees the new value
   always_comb begin
      if (rs_addr == '0) begin
         rs_data = '0;
      end else if (wb.we && (wb.dest == rs_addr)) begin
         rs_data = wb.data;
      end else begin
         rs_data = regs[rs_addr];
      end
   end

   always_comb begin
      if (rt_addr == '0) begin
         rt_data = '0;
      end else if (wb.we && (wb.dest == rt_addr)) begin
         rt_data = wb.data;
      end else begin
         rt_data = regs[rt_addr];
      end
   end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
   input  logic            clk,
   input  logic            reset,
   input  cpu_pkg::instr_u instr,
   input  cpu_pkg::word_t  pc_next_seq,
   input  cpu_pkg::wb_t    wb,
   output logic            branch_taken,
   output cpu_pkg::word_t  branch_target,
   output cpu_pkg::id_ex_t id_ex
);
   import cpu_pkg::*;

   word_t  rs_data;
   word_t  rt_data;
   word_t  imm_ext;
   logic   is_beq;
   logic   is_bne;
   id_ex_t id_ex_next;

   register_file u_regs (
      .clk     (clk),
      .rs_addr (instr.r.rs),
      .rt_addr (instr.r.rt),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .wb      (wb)
   );

   assign imm_ext = {{(XLEN-IMM_W){instr.i.imm[IMM_W-1]}}, instr.i.imm};

   always_comb begin
      id_ex_next           = '0;
      id_ex_next.a         = rs_data;
      id_ex_next.b         = rt_data;
      id_ex_next.imm       = imm_ext;
      id_ex_next.alu_op    = ALU_ADD;
      id_ex_next.set_mode  = SET_NONE;
      // Immediates and loads write rt
      id_ex_next.dest      = instr.i.rt;
      is_beq               = 1'b0;
      is_bne               = 1'b0;
      case (instr.r.opcode)
         OP_RTYPE: begin
            id_ex_next.dest      = instr.r.rd;
            id_ex_next.reg_write = 1'b1;
            case (instr.r.funct)
               FN_XOR: id_ex_next.alu_op = ALU_XOR;
               FN_SUB: id_ex_next.alu_op = ALU_SUB;
               FN_ADD: id_ex_next.alu_op = ALU_ADD;
               FN_OR:  id_ex_next.alu_op = ALU_OR;
               FN_AND: id_ex_next.alu_op = ALU_AND;
               FN_SLT: begin
                  id_ex_next.alu_op   = ALU_SUB;
                  id_ex_next.set_mode = SET_LT;
               end
               FN_SLE: begin
                  id_ex_next.alu_op   = ALU_SUB;
                  id_ex_next.set_mode = SET_LE;
               end
               // Unknown funct, including the no-op, writes nothing
               default: id_ex_next.reg_write = 1'b0;
            endcase
         end
         OP_XORI, OP_SUBI, OP_ADDI, OP_ORI, OP_ANDI: begin
            id_ex_next.use_imm   = 1'b1;
            id_ex_next.reg_write = 1'b1;
            case (instr.i.opcode)
               OP_XORI: id_ex_next.alu_op = ALU_XOR;
               OP_SUBI: id_ex_next.alu_op = ALU_SUB;
               OP_ORI:  id_ex_next.alu_op = ALU_OR;
               OP_ANDI: id_ex_next.alu_op = ALU_AND;
               default: id_ex_next.alu_op = ALU_ADD;
            endcase
         end
         OP_LW: begin
            id_ex_next.use_imm   = 1'b1;
            id_ex_next.reg_write = 1'b1;
            id_ex_next.mem_read  = 1'b1;
         end
         OP_SW: begin
            id_ex_next.use_imm   = 1'b1;
            id_ex_next.mem_write = 1'b1;
         end
         OP_BEQ: is_beq = 1'b1;
         OP_BNE: is_bne = 1'b1;
         default: ;
      endcase
   end

   // Branches resolve here, the next fetched word is the delay slot
   assign branch_taken  = (is_beq && (rs_data == rt_data)) ||
                          (is_bne && (rs_data != rt_data));
   assign branch_target = pc_next_seq + {imm_ext[XLEN-3:0], 2'b00};

   always_ff @(posedge clk) begin
      id_ex <= id_ex_next;
      if (reset) begin
         id_ex.reg_write <= 1'b0;
         id_ex.mem_read  <= 1'b0;
         id_ex.mem_write <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
   input  logic             clk,
   input  logic             reset,
   input  cpu_pkg::id_ex_t  id_ex,
   output cpu_pkg::ex_mem_t ex_mem
);
   import cpu_pkg::*;

   word_t       op_b;
   logic [XLEN:0] sub_full;
   word_t       diff;
   logic        no_borrow;
   word_t       alu_out;
   ex_mem_t     ex_mem_next;

   assign op_b = id_ex.use_imm ? id_ex.imm : id_ex.b;

   // a - b as a + ~b + 1, carry out set means a >= b unsigned
   assign sub_full  = {1'b0, id_ex.a} + {1'b0, ~op_b} + {{XLEN{1'b0}}, 1'b1};
   assign diff      = sub_full[XLEN-1:0];
   assign no_borrow = sub_full[XLEN];

   always_comb begin
      case (id_ex.alu_op)
         ALU_XOR: alu_out = id_ex.a ^ op_b;
         ALU_SUB: alu_out = diff;
         ALU_ADD: alu_out = id_ex.a + op_b;
         ALU_OR:  alu_out = id_ex.a | op_b;
         ALU_AND: alu_out = id_ex.a & op_b;
         default: alu_out = id_ex.a + op_b;
      endcase
   end

   always_comb begin
      ex_mem_next            = '0;
      ex_mem_next.store_data = id_ex.b;
      ex_mem_next.dest       = id_ex.dest;
      ex_mem_next.reg_write  = id_ex.reg_write;
      ex_mem_next.mem_read   = id_ex.mem_read;
      ex_mem_next.mem_write  = id_ex.mem_write;
      case (id_ex.set_mode)
         SET_LT:  ex_mem_next.result = {{(XLEN-1){1'b0}}, ~no_borrow};
         // Less or equal is a borrow or an exact match
         SET_LE:  ex_mem_next.result = {{(XLEN-1){1'b0}}, ~no_borrow | (diff == '0)};
         default: ex_mem_next.result = alu_out;
      endcase
   end

   always_ff @(posedge clk) begin
      ex_mem <= ex_mem_next;
      if (reset) begin
         ex_mem.reg_write <= 1'b0;
         ex_mem.mem_read  <= 1'b0;
         ex_mem.mem_write <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- result_stage.sv
`timescale 1ns/100ps
`default_nettype none

module result_stage (
   input  logic             clk,
   input  logic             reset,
   input  cpu_pkg::ex_mem_t ex_mem,
   output cpu_pkg::word_t   mem_addr,
   output cpu_pkg::word_t   mem_wdata,
   output logic             mem_write,
   output logic             mem_read,
   input  cpu_pkg::word_t   mem_rdata,
   output cpu_pkg::wb_t     wb
);
   import cpu_pkg::*;

   // ALU result doubles as the data address for loads and stores
   assign mem_addr  = ex_mem.result;
   assign mem_wdata = ex_mem.store_data;
   assign mem_write = ex_mem.mem_write;
   assign mem_read  = ex_mem.mem_read;

   // Load data is valid in the same cycle as mem_read
   always_ff @(posedge clk) begin
      wb.dest <= ex_mem.dest;
      if (ex_mem.mem_read) begin
         wb.data <= mem_rdata;
      end else begin
         wb.data <= ex_mem.result;
      end
      if (reset) begin
         wb.we <= 1'b0;
      end else begin
         wb.we <= ex_mem.reg_write;
      end
   end

endmodule

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
   input  logic           clk,
   input  logic           reset,
   output cpu_pkg::word_t imem_addr,
   input  cpu_pkg::word_t imem_data,
   output cpu_pkg::word_t mem_addr,
   output cpu_pkg::word_t mem_wdata,
   output logic           mem_write,
   output logic           mem_read,
   input  cpu_pkg::word_t mem_rdata
);
   import cpu_pkg::*;

   instr_u  instr;
   word_t   pc_next_seq;
   word_t   branch_target;
   logic    branch_taken;
   id_ex_t  id_ex;
   ex_mem_t ex_mem;
   wb_t     wb;

   fetch_unit u_fetch (
      .clk           (clk),
      .reset         (reset),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .imem_addr     (imem_addr),
      .imem_data     (imem_data),
      .instr         (instr),
      .pc_next_seq   (pc_next_seq)
   );

   decode_stage u_decode (
      .clk           (clk),
      .reset         (reset),
      .instr         (instr),
      .pc_next_seq   (pc_next_seq),
      .wb            (wb),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .id_ex         (id_ex)
   );

   execute_stage u_execute (
      .clk    (clk),
      .reset  (reset),
      .id_ex  (id_ex),
      .ex_mem (ex_mem)
   );

   // Memory access and writeback share one stage module
   result_stage u_result (
      .clk       (clk),
      .reset     (reset),
      .ex_mem    (ex_mem),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_write (mem_write),
      .mem_read  (mem_read),
      .mem_rdata (mem_rdata),
      .wb        (wb)
   );

endmodule

`default_nettype wire

//--- tb_cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_top;
   import cpu_pkg::*;

   logic  clk;
   logic  reset;
   word_t imem_addr;
   word_t imem_data;
   word_t mem_addr;
   word_t mem_wdata;
   logic  mem_write;
   logic  mem_read;
   word_t mem_rdata;

   word_t imem [1024];
   word_t dmem [1024];
   word_t log_addr [$];
   word_t log_data [$];
   word_t exp_addr [$];
   word_t exp_data [$];
   word_t read_log [$];
   word_t exp_read [$];
   int    pc_idx;

   cpu_top i_dut (
      .clk       (clk),
      .reset     (reset),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_write (mem_write),
      .mem_read  (mem_read),
      .mem_rdata (mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Both memories answer in the same cycle
   assign imem_data = imem[imem_addr[11:2]];
   assign mem_rdata = dmem[mem_addr[11:2]];

   always @(posedge clk) begin
      if (mem_write) begin
         dmem[mem_addr[11:2]] <= mem_wdata;
         log_addr.push_back(mem_addr);
         log_data.push_back(mem_wdata);
      end
      if (mem_read) begin
         read_log.push_back(mem_addr);
      end
   end

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic check_value(input string name, input word_t got, input word_t expected);
      if (got !== expected) begin
         $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, expected);
         $display(">>> FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic word_t sign_extend(input logic [15:0] v);
      return {{16{v[15]}}, v};
   endfunction

   function automatic word_t r_instr(input logic [5:0] funct, input reg_addr_t rs,
                                     input reg_addr_t rt, input reg_addr_t rd);
      instr_u w;
      w          = '0;
      w.r.opcode = OP_RTYPE;
      w.r.rs     = rs;
      w.r.rt     = rt;
      w.r.rd     = rd;
      w.r.funct  = funct;
      return w;
   endfunction

   function automatic word_t i_instr(input logic [5:0] opcode, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
      instr_u w;
      w.i.opcode = opcode;
      w.i.rs     = rs;
      w.i.rt     = rt;
      w.i.imm    = imm;
      return w;
   endfunction

   // Holds reset while a fresh program is written
   task automatic new_program();
      reset = 1'b1;
      foreach (imem[k]) imem[k] = '0;
      pc_idx = 0;
      exp_addr.delete();
      exp_data.delete();
      exp_read.delete();
   endtask

   task automatic emit(input word_t w);
      imem[pc_idx] = w;
      pc_idx++;
   endtask

   // Two no-ops cover the missing forwarding
   task automatic emit_gap(input word_t w);
      emit(w);
      emit('0);
      emit('0);
   endtask

   task automatic push_expect(input word_t addr, input word_t data);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   task automatic load_const(input reg_addr_t rd, input logic [15:0] imm);
      emit_gap(i_instr(OP_ADDI, 5'd0, rd, imm));
   endtask

   task automatic expect_sw(input reg_addr_t rt, input logic [15:0] addr, input word_t data);
      emit_gap(i_instr(OP_SW, 5'd0, rt, addr));
      push_expect(word_t'(addr), data);
   endtask

   task automatic release_reset();
      repeat (3) step();
      log_addr.delete();
      log_data.delete();
      read_log.delete();
      reset = 1'b0;
   endtask

   task automatic wait_stores(input int n, input string name);
      int cycles;
      cycles = 0;
      while (log_addr.size() < n && cycles < 500) begin
         step();
         cycles++;
      end
      if (log_addr.size() < n) begin
         $display("Timed out in %s after %0d cycles waiting for %0d stores, saw %0d",
                  name, cycles, n, log_addr.size());
         $display(">>> FAIL");
         $fatal(1, "store wait timed out");
      end
   endtask

   task automatic check_stores(input string name);
      // Let trailing instructions drain so extra stores show up
      repeat (12) step();
      check_value({name, " store count"}, log_addr.size(), exp_addr.size());
      foreach (exp_addr[k]) begin
         check_value($sformatf("%s store %0d mem_addr", name, k), log_addr[k], exp_addr[k]);
         check_value($sformatf("%s store %0d mem_wdata", name, k), log_data[k], exp_data[k]);
      end
   endtask

   task automatic check_loads(input string name);
      check_value({name, " load count"}, read_log.size(), exp_read.size());
      foreach (exp_read[k]) begin
         check_value($sformatf("%s load %0d mem_addr", name, k), read_log[k], exp_read[k]);
      end
   endtask

   task automatic run_program(input string name);
      release_reset();
      wait_stores(exp_addr.size(), name);
      check_stores(name);
      check_loads(name);
   endtask

   task automatic test_reg_ops();
      logic [15:0] ia;
      logic [15:0] ib;
      word_t       a;
      word_t       b;
      ia = $urandom;
      ib = $urandom;
      a  = sign_extend(ia);
      b  = sign_extend(ib);
      new_program();
      load_const(1, ia);
      load_const(2, ib);
      emit_gap(r_instr(FN_XOR, 1, 2, 3));
      emit_gap(r_instr(FN_SUB, 1, 2, 4));
      emit_gap(r_instr(FN_ADD, 1, 2, 5));
      emit_gap(r_instr(FN_OR, 1, 2, 6));
      emit_gap(r_instr(FN_AND, 1, 2, 7));
      expect_sw(3, 16'h0100, a ^ b);
      expect_sw(4, 16'h0104, a - b);
      expect_sw(5, 16'h0108, a + b);
      expect_sw(6, 16'h010C, a | b);
      expect_sw(7, 16'h0110, a & b);
      run_program("register ops");
   endtask

   task automatic test_imm_ops();
      logic [15:0] ia;
      logic [15:0] n [4];
      word_t       a;
      ia = $urandom;
      a  = sign_extend(ia);
      foreach (n[k]) n[k] = $urandom | 16'h8000;
      new_program();
      load_const(1, ia);
      emit_gap(i_instr(OP_XORI, 1, 2, n[0]));
      emit_gap(i_instr(OP_SUBI, 1, 3, n[1]));
      emit_gap(i_instr(OP_ORI, 1, 4, n[2]));
      emit_gap(i_instr(OP_ANDI, 1, 5, n[3]));
      expect_sw(2, 16'h0180, a ^ sign_extend(n[0]));
      expect_sw(3, 16'h0184, a - sign_extend(n[1]));
      expect_sw(4, 16'h0188, a | sign_extend(n[2]));
      expect_sw(5, 16'h018C, a & sign_extend(n[3]));
      run_program("immediate ops");
   endtask

   task automatic test_compares();
      logic [15:0] iv;
      logic [15:0] iw;
      word_t       v;
      word_t       w;
      iv = $urandom;
      iw = $urandom;
      if (iw == iv) iw = iv ^ 16'h0001;
      v = sign_extend(iv);
      w = sign_extend(iw);
      new_program();
      load_const(1, iv);
      load_const(2, iv);
      load_const(3, iw);
      // Attempted write to register 0
      emit_gap(i_instr(OP_ADDI, 0, 0, 16'h1234));
      emit_gap(r_instr(FN_SLT, 1, 2, 4));
      emit_gap(r_instr(FN_SLE, 1, 2, 5));
      emit_gap(r_instr(FN_SLT, 1, 3, 6));
      emit_gap(r_instr(FN_SLT, 3, 1, 7));
      emit_gap(r_instr(FN_SLE, 1, 3, 8));
      emit_gap(r_instr(FN_SLE, 3, 1, 9));
      emit_gap(r_instr(FN_SLT, 0, 1, 10));
      emit_gap(r_instr(FN_ADD, 0, 1, 11));
      expect_sw(4, 16'h0200, 32'd0);
      expect_sw(5, 16'h0204, 32'd1);
      expect_sw(6, 16'h0208, word_t'(v < w));
      expect_sw(7, 16'h020C, word_t'(w < v));
      expect_sw(8, 16'h0210, word_t'(v <= w));
      expect_sw(9, 16'h0214, word_t'(w <= v));
      expect_sw(10, 16'h0218, word_t'(32'd0 < v));
      expect_sw(11, 16'h021C, v);
      expect_sw(0, 16'h0220, 32'd0);
      run_program("compares");
   endtask

   task automatic test_load_store();
      logic [15:0] ia;
      logic [15:0] addr;
      word_t       a;
      ia   = $urandom;
      a    = sign_extend(ia);
      addr = 16'h0800 + 16'(($urandom % 512) * 4);
      new_program();
      load_const(1, ia);
      expect_sw(1, addr, a);
      emit_gap(i_instr(OP_LW, 0, 2, addr));
      exp_read.push_back(word_t'(addr));
      expect_sw(2, 16'h0040, a);
      run_program("load store");
   endtask

   // Branch skips one slot past the delay slot when taken
   task automatic branch_case(input logic [5:0] op, input reg_addr_t rs, input reg_addr_t rt,
                              input logic taken, input logic [15:0] base);
      emit(i_instr(op, rs, rt, 16'd2));
      emit(i_instr(OP_SW, 0, 10, base));
      emit(i_instr(OP_SW, 0, 11, base + 16'd4));
      emit(i_instr(OP_SW, 0, 12, base + 16'd8));
      push_expect(word_t'(base), 32'h0AAA);
      if (!taken) push_expect(word_t'(base + 16'd4), 32'h0BBB);
      push_expect(word_t'(base + 16'd8), 32'h0CCC);
   endtask

   task automatic test_branches();
      logic [15:0] iv;
      logic [15:0] iw;
      iv = $urandom;
      iw = iv ^ 16'h0100;
      new_program();
      load_const(1, iv);
      load_const(2, iv);
      load_const(3, iw);
      load_const(10, 16'h0AAA);
      load_const(11, 16'h0BBB);
      load_const(12, 16'h0CCC);
      branch_case(OP_BEQ, 1, 2, 1'b1, 16'h0300);
      branch_case(OP_BEQ, 1, 3, 1'b0, 16'h0320);
      branch_case(OP_BNE, 1, 3, 1'b1, 16'h0340);
      branch_case(OP_BNE, 1, 2, 1'b0, 16'h0360);
      run_program("branches");
   endtask

   task automatic test_mid_reset();
      logic [15:0] iv;
      word_t       v;
      iv = $urandom;
      v  = sign_extend(iv);
      new_program();
      load_const(1, iv);
      emit(i_instr(OP_SW, 0, 1, 16'h0500));
      emit('0);
      emit(i_instr(OP_SW, 0, 1, 16'h0504));
      push_expect(32'h0500, v);
      release_reset();
      wait_stores(1, "mid reset first store");
      // Second store is in execute when reset hits
      reset = 1'b1;
      repeat (2) begin
         step();
         check_value("mem_write in reset", word_t'(mem_write), 32'd0);
      end
      step();
      reset = 1'b0;
      check_value("mem_write after reset", word_t'(mem_write), 32'd0);
      check_value("imem_addr after reset", imem_addr, 32'd0);
      step();
      check_value("mem_write after reset", word_t'(mem_write), 32'd0);
      push_expect(32'h0500, v);
      push_expect(32'h0504, v);
      wait_stores(3, "mid reset restart");
      check_stores("mid reset");
      check_loads("mid reset");
   endtask

   initial begin
      void'($urandom(32'h5663_387a));
      reset = 1'b1;
      foreach (imem[k]) imem[k] = '0;
      // Fill word depends on the full byte address
      foreach (dmem[k]) dmem[k] = word_t'(k * 4) ^ 32'hD00D_0000;
      test_reg_ops();
      test_imm_ops();
      test_compares();
      test_load_store();
      test_branches();
      test_mid_reset();
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
cpu_pkg.sv
fetch_unit.sv
register_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
cpu_top.sv
tb_cpu_top.sv

//--- Bender.yml
package:
  name: cpu_top

sources:
  - cpu_pkg.sv
  - fetch_unit.sv
  - register_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - result_stage.sv
  - cpu_top.sv
  - target: test
    files:
      - tb_cpu_top.sv
